/* verilog/player_defs.svh */
// shared sizes for the sample player; FIFO depth must be 2 or more, track length fits the address
`ifndef PLAYER_DEFS_SVH
`define PLAYER_DEFS_SVH

// flash word address width
// covers 8M words of 32 bits
`define PLAYER_ADDR_W 23

// entries in each FIFO
// word FIFO and sample FIFO share it
`define PLAYER_FIFO_DEPTH 4

// codec scaling, divisor is 1 << shift
// 6 gives the divide by 64
`define PLAYER_SCALE_SHIFT 6

// default track length in words
// one full flash part of 1M words
`define PLAYER_DEFAULT_WORDS 1048576

`endif

/* verilog/player_pkg.sv */
// types shared by the sample player; samples are signed 16 bit, two per flash word, low half first
package player_pkg;

	// one flash word
	// bits 15:0 play first, bits 31:16 second
	typedef logic [31:0] flash_word_t;

	// one signed audio sample
	// same width on left and right codec channels
	typedef logic signed [15:0] sample_t;

	// playback mode from the switches
	// code 3 is not listed and plays as normal
	typedef enum logic [1:0] {
		mode_normal = 2'd0,
		// low sample only, double speed
		mode_fast   = 2'd1,
		// every sample twice, half speed
		mode_slow   = 2'd2
	} play_mode_t;

endpackage

/* verilog/flash_reader.sv */
// single-outstanding flash reader; caller must keep the FIFO able to take the word in flight
`include "player_defs.svh"

module flash_reader #(
	parameter int num_words = `PLAYER_DEFAULT_WORDS
) (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        flash_read,
	output logic [`PLAYER_ADDR_W-1:0]   flash_address,
	input  logic                        flash_waitrequest,
	input  player_pkg::flash_word_t     flash_readdata,
	input  logic                        flash_readdatavalid,
	input  logic                        word_fifo_room,
	output player_pkg::flash_word_t     word,
	output logic                        word_push,
	output logic                        last_word
);

	localparam int addr_w = `PLAYER_ADDR_W;
	// address of the final word of the track
	localparam logic [addr_w-1:0] last_addr = addr_w'(num_words - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_await
	} state_t;

	state_t state;
	// all num_words reads have been accepted
	logic   finished;
	// the read in flight is the final one
	logic   is_last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= st_idle;
			flash_address <= '0;
			finished      <= 1'b0;
			is_last       <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// room test keeps a spare slot past the word in flight
					if (!finished && word_fifo_room)
						state <= st_request;
				end
				st_request: begin
					// read accepted on a cycle with waitrequest low
					if (!flash_waitrequest) begin
						state   <= st_await;
						is_last <= (flash_address == last_addr);
						// address parks on the last word, never reaches num_words
						if (flash_address == last_addr)
							finished <= 1'b1;
						else
							flash_address <= flash_address + 1'b1;
					end
				end
				st_await: begin
					// data lands in the FIFO this same cycle
					if (flash_readdatavalid)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// read and address held steady for the whole request state
	assign flash_read = (state == st_request);

	// returned word goes straight to the FIFO
	assign word      = flash_readdata;
	assign word_push = (state == st_await) && flash_readdatavalid;
	// end-of-track mark rides along with the word
	assign last_word = is_last;

endmodule

/* verilog/sync_fifo.sv */
// synchronous FIFO for any packed payload; writes while full and reads while empty are ignored
`include "player_defs.svh"

module sync_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full,
	output logic     room_for_two
);

	localparam int depth = `PLAYER_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);
	// count needs one more value than pointers
	localparam int cnt_w = $clog2(depth + 1);

	payload_t           mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [cnt_w-1:0]   count;
	logic               do_push;
	logic               do_pop;

	// wrap at depth, also for depths that are not a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// count moves only when push and pop differ
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head valid one cycle after the push
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == cnt_w'(depth));
	// two free slots, for a producer with a request in flight
	assign room_for_two = (count <= cnt_w'(depth - 2));

endmodule

/* verilog/rate_shaper.sv */
// word to sample splitter; mode is sampled once per word, so a change takes effect on the next word
`include "player_defs.svh"

module rate_shaper (
	input  logic                    clk,
	input  logic                    rst_n,
	input  player_pkg::play_mode_t  mode,
	input  player_pkg::flash_word_t word,
	input  logic                    word_last,
	input  logic                    word_empty,
	output logic                    word_pop,
	output player_pkg::sample_t     sample,
	output logic                    sample_last,
	output logic                    sample_push,
	input  logic                    sample_full
);

	import player_pkg::*;

	// added to negatives before the shift, gives truncation toward zero
	localparam sample_t round_bias = sample_t'((1 << `PLAYER_SCALE_SHIFT) - 1);

	// a word is taken from the FIFO head
	logic       active;
	play_mode_t cur_mode;
	// position in the sample order of the current word
	logic [1:0] step;
	logic [1:0] last_step;
	logic       at_last;
	logic       high_half;
	sample_t    raw;
	sample_t    bias;
	sample_t    biased;

	// sample order per mode
	// code 3 falls to the default, same as normal
	always_comb begin
		case (cur_mode)
			mode_fast: begin
				// low half only, high half dropped
				last_step = 2'd0;
				high_half = 1'b0;
			end
			mode_slow: begin
				// low, low, high, high
				last_step = 2'd3;
				high_half = step[1];
			end
			default: begin
				// low then high
				last_step = 2'd1;
				high_half = step[0];
			end
		endcase
	end

	assign at_last = (step == last_step);

	// pick the half and scale it
	always_comb begin
		raw    = high_half ? word[31:16] : word[15:0];
		bias   = raw[15] ? round_bias : sample_t'(0);
		biased = raw + bias;
		// signed operand, so this shift is arithmetic
		sample = biased >>> `PLAYER_SCALE_SHIFT;
	end

	// one sample per cycle, held off by a full sample FIFO
	assign sample_push = active && !sample_full;
	// only the final sample of the final word carries the mark
	assign sample_last = word_last && at_last;
	// word leaves the FIFO with its last sample
	assign word_pop    = sample_push && at_last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			step     <= 2'd0;
			cur_mode <= mode_normal;
		end else if (!active) begin
			// take the head word, latch its mode
			if (!word_empty) begin
				active   <= 1'b1;
				cur_mode <= mode;
				step     <= 2'd0;
			end
		end else if (sample_push) begin
			if (at_last) begin
				active <= 1'b0;
				step   <= 2'd0;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

endmodule

/* verilog/codec_writer.sv */
// codec write side only; assumes write_ready falls once per sample after write_s is seen
module codec_writer (
	input  logic                clk,
	input  logic                rst_n,
	input  player_pkg::sample_t sample,
	input  logic                sample_last,
	input  logic                sample_empty,
	output logic                sample_pop,
	input  logic                write_ready,
	output logic                write_s,
	output player_pkg::sample_t writedata_left,
	output player_pkg::sample_t writedata_right,
	output logic                done
);

	typedef enum logic [1:0] {
		st_wait,
		st_send,
		st_done
	} state_t;

	state_t state;
	// ready low while sending is the falling edge, sample taken
	logic   accepted;

	assign accepted = (state == st_send) && !write_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_wait;
		end else begin
			case (state)
				st_wait: begin
					// need a sample and a ready codec
					if (!sample_empty && write_ready)
						state <= st_send;
				end
				st_send: begin
					// write_s drops the cycle after the fall
					if (accepted)
						state <= sample_last ? st_done : st_wait;
				end
				// parked until reset
				st_done: state <= st_done;
				default: state <= st_wait;
			endcase
		end
	end

	assign write_s    = (state == st_send);
	// head only leaves once the codec has it
	assign sample_pop = accepted;

	// mono source, both channels equal
	// head stays put while sending, so data holds with write_s
	assign writedata_left  = sample;
	assign writedata_right = sample;

	// high the cycle after the last sample is accepted
	assign done = (state == st_done);

endmodule

/* verilog/sample_player.sv */
// flash to codec player top; no codec serial side, no flash writes, track length fixed by num_words
`include "player_defs.svh"

module sample_player #(
	parameter int num_words = `PLAYER_DEFAULT_WORDS
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  player_pkg::play_mode_t      mode,
	output logic                        flash_read,
	output logic [`PLAYER_ADDR_W-1:0]   flash_address,
	input  logic                        flash_waitrequest,
	input  player_pkg::flash_word_t     flash_readdata,
	input  logic                        flash_readdatavalid,
	input  logic                        write_ready,
	output logic                        write_s,
	output player_pkg::sample_t         writedata_left,
	output player_pkg::sample_t         writedata_right,
	output logic                        done
);

	import player_pkg::*;

	localparam int word_w   = $bits(flash_word_t);
	localparam int sample_w = $bits(sample_t);

	// FIFO entries, end-of-track flag on top
	typedef logic [word_w:0]   word_entry_t;
	typedef logic [sample_w:0] sample_entry_t;

	// reader to word FIFO
	flash_word_t   rd_word;
	logic          rd_push;
	logic          rd_last;
	logic          word_room;
	// word FIFO to shaper
	word_entry_t   word_head;
	logic          word_empty;
	logic          word_pop;
	// shaper to sample FIFO
	sample_t       sh_sample;
	logic          sh_last;
	logic          sh_push;
	logic          sample_full;
	// sample FIFO to writer
	sample_entry_t sample_head;
	logic          sample_empty;
	logic          sample_pop;

	flash_reader #(
		.num_words(num_words)
	) flash_reader_inst (
		.clk                (clk),
		.rst_n              (rst_n),
		.flash_read         (flash_read),
		.flash_address      (flash_address),
		.flash_waitrequest  (flash_waitrequest),
		.flash_readdata     (flash_readdata),
		.flash_readdatavalid(flash_readdatavalid),
		.word_fifo_room     (word_room),
		.word               (rd_word),
		.word_push          (rd_push),
		.last_word          (rd_last)
	);

	// room_for_two here, one slot may belong to the read in flight
	sync_fifo #(
		.payload_t(word_entry_t)
	) word_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (rd_push),
		.push_data   ({rd_last, rd_word}),
		.pop         (word_pop),
		.head        (word_head),
		.empty       (word_empty),
		.full        (),
		.room_for_two(word_room)
	);

	rate_shaper rate_shaper_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.word       (word_head[word_w-1:0]),
		.word_last  (word_head[word_w]),
		.word_empty (word_empty),
		.word_pop   (word_pop),
		.sample     (sh_sample),
		.sample_last(sh_last),
		.sample_push(sh_push),
		.sample_full(sample_full)
	);

	sync_fifo #(
		.payload_t(sample_entry_t)
	) sample_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (sh_push),
		.push_data   ({sh_last, sh_sample}),
		.pop         (sample_pop),
		.head        (sample_head),
		.empty       (sample_empty),
		.full        (sample_full),
		.room_for_two()
	);

	codec_writer codec_writer_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample         (sample_head[sample_w-1:0]),
		.sample_last    (sample_head[sample_w]),
		.sample_empty   (sample_empty),
		.sample_pop     (sample_pop),
		.write_ready    (write_ready),
		.write_s        (write_s),
		.writedata_left (writedata_left),
		.writedata_right(writedata_right),
		.done           (done)
	);

endmodule

/* test/tb_sample_player.sv */
// testbench for sample_player with num_words 8; run from the project root so test/player_testdata.txt is found
`include "player_defs.svh"

module tb_sample_player;

	import player_pkg::*;

	localparam int num_words     = 8;
	localparam int clk_period    = 40;
	localparam int drive_delay   = 2;
	localparam int reset_cycles  = 2;
	localparam int idle_cycles   = 20;
	localparam int rand_seed     = 32'h35b8;
	// 16 normal, 8 fast, 32 slow, 16 for mode code 3
	localparam int total_samples = 72;
	localparam int run_count     = 4;
	// reset, quiet window and pipeline fill per run
	localparam int run_overhead  = reset_cycles + idle_cycles + 10;
	localparam int timeout_time  =
		(total_samples * 12 + run_count * run_overhead) * clk_period;
	// where each block starts in the data file
	localparam int normal_base   = 8;
	localparam int fast_base     = 24;
	localparam int slow_base     = 32;
	localparam int data_size     = 64;

	logic                      clk;
	logic                      rst_n;
	play_mode_t                mode;
	logic                      flash_read;
	logic [`PLAYER_ADDR_W-1:0] flash_address;
	logic                      flash_waitrequest;
	flash_word_t               flash_readdata;
	logic                      flash_readdatavalid;
	logic                      write_ready;
	logic                      write_s;
	sample_t                   writedata_left;
	sample_t                   writedata_right;
	logic                      done;

	// flash words, then expected samples per mode
	logic [31:0] testdata [data_size];
	// current run, set by the main sequence
	int exp_base;
	int exp_count;
	int first_sample;
	int first_read;
	// running totals over all runs, one writer each
	int sample_total   = 0;
	int accepted_total = 0;
	int read_total     = 0;

	sample_player #(
		.num_words(num_words)
	) sample_player_inst (
		.clk                (clk),
		.rst_n              (rst_n),
		.mode               (mode),
		.flash_read         (flash_read),
		.flash_address      (flash_address),
		.flash_waitrequest  (flash_waitrequest),
		.flash_readdata     (flash_readdata),
		.flash_readdatavalid(flash_readdatavalid),
		.write_ready        (write_ready),
		.write_s            (write_s),
		.writedata_left     (writedata_left),
		.writedata_right    (writedata_right),
		.done               (done)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// inputs change here, outputs already settled
	task automatic next_drive_point();
		@(posedge clk);
		#(drive_delay);
	endtask

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	// expected codec value, low 16 bits of a data entry
	function automatic sample_t expected_sample(input int idx);
		return sample_t'(testdata[6'(idx)][15:0]);
	endfunction

	// one track after a fresh reset, then a quiet window
	task automatic play_track(input play_mode_t code, input int base, input int count);
		int played;
		next_drive_point();
		rst_n        = 1'b0;
		mode         = code;
		exp_base     = base;
		exp_count    = count;
		first_sample = sample_total;
		first_read   = read_total;
		repeat (reset_cycles) next_drive_point();
		rst_n  = 1'b1;
		played = 0;
		// done must track the last acceptance exactly
		while (played < count) begin
			@(negedge clk);
			played = accepted_total - first_sample;
			assert (done == (played == count)) else
				stop_with_error($sformatf("MISMATCH time=%0t: done is %b with %0d of %0d accepted",
					$time, done, played, count));
		end
		assert (read_total - first_read == num_words) else
			stop_with_error($sformatf("MISMATCH time=%0t: %0d flash reads accepted, expected %0d",
				$time, read_total - first_read, num_words));
		repeat (idle_cycles) begin
			@(negedge clk);
			assert (done && !write_s && !flash_read) else
				stop_with_error("done dropped or bus activity seen after the end of the track");
		end
	endtask

	// flash side, one read at a time with random stalls
	initial begin : flash_model
		int flash_seed;
		int stall;
		int delay;
		int addr;
		flash_seed          = rand_seed;
		flash_waitrequest   = 1'b1;
		flash_readdata      = '0;
		flash_readdatavalid = 1'b0;
		forever begin
			next_drive_point();
			if (flash_read) begin
				stall = 1 + ($unsigned($random(flash_seed)) % 4);
				repeat (stall) next_drive_point();
				assert (flash_read) else
					stop_with_error("flash_read dropped before the read was accepted");
				addr = int'(flash_address);
				assert (addr < num_words) else
					stop_with_error("flash_address reached the track length");
				// addresses must run 0, 1, 2 with no gap or repeat
				assert (addr == read_total - first_read) else
					stop_with_error($sformatf("MISMATCH time=%0t: read address %0d expected %0d",
						$time, addr, read_total - first_read));
				flash_waitrequest = 1'b0;
				next_drive_point();
				flash_waitrequest = 1'b1;
				read_total++;
				delay = 1 + ($unsigned($random(flash_seed)) % 3);
				repeat (delay - 1) next_drive_point();
				flash_readdata      = testdata[6'(addr)];
				flash_readdatavalid = 1'b1;
				next_drive_point();
				flash_readdatavalid = 1'b0;
			end
		end
	end

	// codec side, ready after a random gap, falls 1 to 3 cycles after write_s
	initial begin : codec_model
		int      codec_seed;
		int      gap;
		int      hold;
		int      n;
		sample_t want;
		codec_seed  = rand_seed;
		write_ready = 1'b0;
		forever begin
			gap = $unsigned($random(codec_seed)) % 7;
			repeat (gap) next_drive_point();
			write_ready = 1'b1;
			next_drive_point();
			while (!write_s) begin
				next_drive_point();
			end
			n = sample_total - first_sample;
			assert (n < exp_count) else
				stop_with_error("write_s raised with no sample left in the track");
			want = expected_sample(exp_base + n);
			assert (writedata_left == want && writedata_right == want) else
				stop_with_error($sformatf("MISMATCH time=%0t: sample %0d expected %h, left %h right %h",
					$time, n, want, writedata_left, writedata_right));
			sample_total++;
			hold = 1 + ($unsigned($random(codec_seed)) % 3);
			repeat (hold - 1) next_drive_point();
			write_ready = 1'b0;
			// the edge that sees ready low takes the sample
			next_drive_point();
			accepted_total++;
		end
	end

	initial begin : watchdog
		#(timeout_time);
		stop_with_error("timeout: playback did not finish within the time budget");
	end

	initial begin : main_sequence
		rst_n        = 1'b0;
		mode         = mode_normal;
		exp_base     = normal_base;
		exp_count    = 0;
		first_sample = 0;
		first_read   = 0;
		$readmemh("test/player_testdata.txt", testdata);
		play_track(mode_normal, normal_base, 16);
		play_track(mode_fast, fast_base, 8);
		play_track(mode_slow, slow_base, 32);
		// unlisted code plays like normal
		play_track(play_mode_t'(2'd3), normal_base, 16);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* test/player_testdata.txt */
// entries 0-7: flash words in hex, high sample in bits 31:16, low sample in bits 15:0
// entries 8-63: expected codec samples, zero-extended hex; normal 16, fast 8, slow 32
// flash words
FFC00040
F0001000
FFC1003F
80007FFF
FFFF0000
FF7F0081
EDCC1234
FEFF0100
// normal, low then high per word
00000001 0000FFFF
00000040 0000FFC0
00000000 00000000
000001FF 0000FE00
00000000 00000000
00000002 0000FFFE
00000048 0000FFB8
00000004 0000FFFC
// fast, low halves only
00000001 00000040 00000000 000001FF
00000000 00000002 00000048 00000004
// slow, every sample twice
00000001 00000001 0000FFFF 0000FFFF
00000040 00000040 0000FFC0 0000FFC0
00000000 00000000 00000000 00000000
000001FF 000001FF 0000FE00 0000FE00
00000000 00000000 00000000 00000000
00000002 00000002 0000FFFE 0000FFFE
00000048 00000048 0000FFB8 0000FFB8
00000004 00000004 0000FFFC 0000FFFC

/* tb.f */
+incdir+verilog
verilog/player_pkg.sv
verilog/flash_reader.sv
verilog/sync_fifo.sv
verilog/rate_shaper.sv
verilog/codec_writer.sv
verilog/sample_player.sv
test/tb_sample_player.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sample player testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

verilator --binary --timing --assert -f tb.f --top-module tb_sample_player -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
